//--- src/grom_defs.svh
`ifndef GROM_DEFS_SVH
`define GROM_DEFS_SVH

// Bus widths
`define GROM_ADDR_W 12
`define GROM_DATA_W 8

`define GROM_NREGS 4

// Upper address nibble of every LOAD/STORE
`define GROM_DATA_PAGE 4'hF

`define GROM_RESET_PC 12'h000

`endif

//--- src/grom_pkg.sv
`default_nettype none

package grom_pkg;

	`include "grom_defs.svh"

	typedef logic [$clog2(`GROM_NREGS)-1:0] reg_idx_t;

	// Single-byte view
	typedef struct packed {
		logic       dbl;    // Operand byte follows
		logic [2:0] grp;
		logic [1:0] fld;
		logic [1:0] rsel;
	} instr_reg_t;

	// Two-byte view
	typedef struct packed {
		logic       dbl;
		logic [2:0] grp;
		logic [3:0] nib;    // Condition or target high nibble
	} instr_jmp_t;

	typedef union packed {
		instr_reg_t r;
		instr_jmp_t j;
	} instr_t;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_NOT,
		ALU_XOR
	} alu_op_e;

	typedef enum logic [3:0] {
		CLS_NOP,
		CLS_MOV,
		CLS_MOVI,
		CLS_ALU,
		CLS_FLAGS_ONLY,    // CMP and TST
		CLS_LOAD,
		CLS_LOADI,
		CLS_STORE,
		CLS_STOREI,
		CLS_JCOND,
		CLS_JUMP,
		CLS_HALT
	} instr_class_e;

	typedef struct packed {
		instr_class_e cls;
		alu_op_e      op;
		reg_idx_t     dst;
		reg_idx_t     src;
		logic         use_one;    // INC/DEC second operand
		logic [2:0]   cond;
	} decoded_t;

	typedef struct packed {
		logic                   go;
		alu_op_e                op;
		logic [`GROM_DATA_W-1:0] a;
		logic [`GROM_DATA_W-1:0] b;
	} alu_cmd_t;

	typedef struct packed {
		logic cf;
		logic zf;
		logic sf;
	} flags_t;

	typedef struct packed {
		logic [`GROM_ADDR_W-1:0] addr;
		logic [`GROM_DATA_W-1:0] data_out;
		logic                   we;
	} mem_bus_t;

endpackage

`default_nettype wire

//--- src/grom_alu.sv
`default_nettype none
`include "grom_defs.svh"

module grom_alu (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire grom_pkg::alu_cmd_t      cmd,
	output logic [`GROM_DATA_W-1:0]      result,
	output grom_pkg::flags_t             flags
);
	import grom_pkg::*;

	logic [`GROM_DATA_W:0] sum;    // Top bit is carry or borrow

	always_comb
	begin
		case (cmd.op)
			ALU_ADD: sum = {1'b0, cmd.a} + {1'b0, cmd.b};
			ALU_SUB: sum = {1'b0, cmd.a} - {1'b0, cmd.b};
			ALU_AND: sum = {1'b0, cmd.a & cmd.b};
			ALU_OR:  sum = {1'b0, cmd.a | cmd.b};
			ALU_NOT: sum = {1'b0, ~cmd.b};
			ALU_XOR: sum = {1'b0, cmd.a ^ cmd.b};
			default: sum = {1'b0, cmd.a};
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result <= '0;
			flags  <= '0;
		end
		else if (cmd.go)
		begin
			result   <= sum[`GROM_DATA_W-1:0];
			flags.cf <= sum[`GROM_DATA_W];
			flags.zf <= (sum[`GROM_DATA_W-1:0] == '0);
			flags.sf <= sum[`GROM_DATA_W-1];
		end
	end

endmodule

`default_nettype wire

//--- src/grom_regfile.sv
`default_nettype none
`include "grom_defs.svh"

module grom_regfile (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire grom_pkg::reg_idx_t      rd_a_sel,
	input  wire grom_pkg::reg_idx_t      rd_b_sel,
	input  wire logic                    wr_en,
	input  wire grom_pkg::reg_idx_t      wr_sel,
	input  wire logic [`GROM_DATA_W-1:0] wr_data,
	output logic [`GROM_DATA_W-1:0]      rd_a,
	output logic [`GROM_DATA_W-1:0]      rd_b
);

	logic [`GROM_DATA_W-1:0] regs [`GROM_NREGS];

	always_ff @(posedge clk)
	begin
		if (reset)
			regs <= '{default: '0};
		else if (wr_en)
			regs[wr_sel] <= wr_data;
	end

	// Reads see the old value until the edge
	assign rd_a = regs[rd_a_sel];
	assign rd_b = regs[rd_b_sel];

endmodule

`default_nettype wire

//--- src/grom_decode.sv
`default_nettype none

module grom_decode (
	input  wire grom_pkg::instr_t ir,
	output grom_pkg::decoded_t    dec
);
	import grom_pkg::*;

	always_comb
	begin
		dec.cls     = CLS_NOP;
		dec.op      = ALU_ADD;
		dec.dst     = ir.r.fld;
		dec.src     = ir.r.rsel;
		dec.use_one = 1'b0;
		dec.cond    = ir.j.nib[2:0];
		if (!ir.r.dbl)
		begin
			case (ir.r.grp)
				3'd0: dec.cls = CLS_MOV;
				3'd1:
				begin
					// ADC and SBC fall through as no-ops
					if (!ir.r.fld[1])
					begin
						dec.cls = CLS_ALU;
						dec.op  = ir.r.fld[0] ? ALU_SUB : ALU_ADD;
						dec.dst = '0;
					end
				end
				3'd2:
				begin
					dec.cls = CLS_ALU;
					dec.dst = '0;    // Result into R0
					case (ir.r.fld)
						2'd0: dec.op = ALU_AND;
						2'd1: dec.op = ALU_OR;
						2'd2: dec.op = ALU_NOT;
						default: dec.op = ALU_XOR;
					endcase
				end
				3'd3:
				begin
					case (ir.r.fld)
						2'd0:
						begin
							dec.cls     = CLS_ALU;
							dec.dst     = ir.r.rsel;
							dec.use_one = 1'b1;
						end
						2'd1:
						begin
							dec.cls     = CLS_ALU;
							dec.op      = ALU_SUB;
							dec.dst     = ir.r.rsel;
							dec.use_one = 1'b1;
						end
						2'd2:
						begin
							dec.cls = CLS_FLAGS_ONLY;
							dec.op  = ALU_SUB;
							dec.dst = '0;
						end
						default:
						begin
							dec.cls = CLS_FLAGS_ONLY;
							dec.op  = ALU_AND;
							dec.dst = '0;
						end
					endcase
				end
				3'd5: dec.cls = CLS_LOAD;
				3'd6: dec.cls = CLS_STORE;
				3'd7:
				begin
					if (ir.r.fld == 2'b11 && ir.r.rsel == 2'b11)
						dec.cls = CLS_HALT;
				end
				default: dec.cls = CLS_NOP;    // Shifts, PUSH, POP
			endcase
		end
		else
		begin
			dec.dst = ir.j.nib[1:0];
			case (ir.j.grp)
				3'd0:
				begin
					if (!ir.j.nib[3] && ir.j.nib[2:0] != 3'b111)
						dec.cls = CLS_JCOND;
				end
				3'd1: dec.cls = CLS_JUMP;
				3'd7:
				begin
					case (ir.j.nib[3:2])
						2'd0: dec.cls = CLS_MOVI;
						2'd1: dec.cls = CLS_LOADI;
						2'd2: dec.cls = CLS_STOREI;
						default: dec.cls = CLS_NOP;
					endcase
				end
				default: dec.cls = CLS_NOP;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/grom_control.sv
`default_nettype none
`include "grom_defs.svh"

module grom_control (
	input  wire logic                    clk,
	input  wire logic                    reset,
	input  wire logic [`GROM_DATA_W-1:0] data_in,
	output grom_pkg::mem_bus_t           bus,
	output logic                         hlt,
	output grom_pkg::instr_t             ir,
	input  wire grom_pkg::decoded_t      dec,
	output grom_pkg::reg_idx_t           rd_a_sel,
	output grom_pkg::reg_idx_t           rd_b_sel,
	input  wire logic [`GROM_DATA_W-1:0] rd_a,
	input  wire logic [`GROM_DATA_W-1:0] rd_b,
	output logic                         wr_en,
	output grom_pkg::reg_idx_t           wr_sel,
	output logic [`GROM_DATA_W-1:0]      wr_data,
	output grom_pkg::alu_cmd_t           alu_cmd,
	input  wire logic [`GROM_DATA_W-1:0] alu_res,
	input  wire grom_pkg::flags_t        flags
);
	import grom_pkg::*;

	typedef enum logic [3:0] {
		S_RESET,
		S_FETCH_PREP,
		S_FETCH_WAIT,
		S_FETCH,
		S_EXECUTE,
		S_VALUE_PREP,
		S_VALUE,
		S_EXECUTE_DBL,
		S_LOAD_WAIT,
		S_LOAD_VALUE,
		S_ALU_WAIT,
		S_ALU_RESULT
	} state_e;

	state_e                  state;
	logic [`GROM_ADDR_W-1:0] pc;
	logic [`GROM_DATA_W-1:0] operand;    // Second instruction byte
	reg_idx_t                res_sel;    // Write-back target
	logic                    take;

	assign rd_a_sel = dec.dst;
	assign rd_b_sel = dec.src;

	always_comb
	begin
		case (dec.cond)
			3'd0: take = 1'b1;
			3'd1: take = flags.cf;
			3'd2: take = !flags.cf;
			3'd3: take = flags.sf;
			3'd4: take = !flags.sf;
			3'd5: take = flags.zf;
			3'd6: take = !flags.zf;
			default: take = 1'b0;
		endcase
	end

	always_comb
	begin
		wr_en   = 1'b0;
		wr_sel  = dec.dst;
		wr_data = rd_b;
		case (state)
			S_EXECUTE: wr_en = (dec.cls == CLS_MOV);
			S_EXECUTE_DBL:
			begin
				wr_en   = (dec.cls == CLS_MOVI);
				wr_data = operand;
			end
			S_LOAD_VALUE:
			begin
				wr_en   = 1'b1;
				wr_sel  = res_sel;
				wr_data = data_in;
			end
			S_ALU_RESULT:
			begin
				wr_en   = 1'b1;
				wr_sel  = res_sel;
				wr_data = alu_res;
			end
			default: wr_en = 1'b0;
		endcase
	end

	always_ff @(posedge clk)
	begin
		alu_cmd.go <= 1'b0;    // Single-cycle pulse
		if (reset)
		begin
			state  <= S_RESET;
			pc     <= `GROM_RESET_PC;
			bus.we <= 1'b0;
			hlt    <= 1'b0;
		end
		else
		begin
			case (state)
				S_RESET: state <= S_FETCH_PREP;
				S_FETCH_PREP:
				begin
					bus.addr <= pc;
					bus.we   <= 1'b0;
					state    <= S_FETCH_WAIT;
				end
				S_FETCH_WAIT: state <= hlt ? S_FETCH_PREP : S_FETCH;    // Halted loops here
				S_FETCH:
				begin
					ir    <= data_in;
					pc    <= pc + 1'b1;
					state <= S_EXECUTE;
				end
				S_EXECUTE:
				begin
					res_sel <= dec.dst;
					state   <= S_FETCH_PREP;
					if (ir.r.dbl)
					begin
						bus.addr <= pc;
						pc       <= pc + 1'b1;
						state    <= S_VALUE_PREP;
					end
					else
					begin
						case (dec.cls)
							CLS_ALU, CLS_FLAGS_ONLY:
							begin
								alu_cmd.go <= 1'b1;
								alu_cmd.op <= dec.op;
								alu_cmd.a  <= rd_a;
								alu_cmd.b  <= dec.use_one ? `GROM_DATA_W'(1) : rd_b;
								if (dec.cls == CLS_ALU)
									state <= S_ALU_WAIT;
							end
							CLS_LOAD:
							begin
								bus.addr <= {`GROM_DATA_PAGE, rd_b};
								state    <= S_LOAD_WAIT;
							end
							CLS_STORE:
							begin
								bus.addr     <= {`GROM_DATA_PAGE, rd_a};
								bus.data_out <= rd_b;
								bus.we       <= 1'b1;
							end
							CLS_HALT: hlt <= 1'b1;
							default: hlt <= hlt;
						endcase
					end
				end
				S_VALUE_PREP: state <= S_VALUE;
				S_VALUE:
				begin
					operand <= data_in;
					state   <= S_EXECUTE_DBL;
				end
				S_EXECUTE_DBL:
				begin
					res_sel <= dec.dst;
					state   <= S_FETCH_PREP;
					case (dec.cls)
						CLS_JCOND:
						begin
							// Stays inside the current code page
							if (take)
								pc <= {pc[`GROM_ADDR_W-1:`GROM_DATA_W], operand};
						end
						CLS_JUMP: pc <= {ir.j.nib, operand};
						CLS_LOADI:
						begin
							bus.addr <= {`GROM_DATA_PAGE, operand};
							state    <= S_LOAD_WAIT;
						end
						CLS_STOREI:
						begin
							bus.addr     <= {`GROM_DATA_PAGE, operand};
							bus.data_out <= rd_b;
							bus.we       <= 1'b1;
						end
						default: pc <= pc;
					endcase
				end
				S_LOAD_WAIT: state <= S_LOAD_VALUE;
				S_ALU_WAIT: state <= S_ALU_RESULT;
				S_LOAD_VALUE, S_ALU_RESULT: state <= S_FETCH_PREP;
				default: state <= S_FETCH_PREP;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- src/grom_cpu.sv
`default_nettype none
`include "grom_defs.svh"

module grom_cpu (
	input  wire logic                    clk,
	input  wire logic                    reset,
	output logic [`GROM_ADDR_W-1:0]      addr,
	input  wire logic [`GROM_DATA_W-1:0] data_in,
	output logic [`GROM_DATA_W-1:0]      data_out,
	output logic                         we,
	output logic                         hlt
);
	import grom_pkg::*;

	mem_bus_t                bus;
	instr_t                  ir;
	decoded_t                dec;
	reg_idx_t                rd_a_sel;
	reg_idx_t                rd_b_sel;
	reg_idx_t                wr_sel;
	logic [`GROM_DATA_W-1:0] rd_a;
	logic [`GROM_DATA_W-1:0] rd_b;
	logic                    wr_en;
	logic [`GROM_DATA_W-1:0] wr_data;
	alu_cmd_t                alu_cmd;
	logic [`GROM_DATA_W-1:0] alu_res;
	flags_t                  flags;

	grom_control u_control (
		.clk      (clk),
		.reset    (reset),
		.data_in  (data_in),
		.bus      (bus),
		.hlt      (hlt),
		.ir       (ir),
		.dec      (dec),
		.rd_a_sel (rd_a_sel),
		.rd_b_sel (rd_b_sel),
		.rd_a     (rd_a),
		.rd_b     (rd_b),
		.wr_en    (wr_en),
		.wr_sel   (wr_sel),
		.wr_data  (wr_data),
		.alu_cmd  (alu_cmd),
		.alu_res  (alu_res),
		.flags    (flags)
	);

	grom_decode u_decode (
		.ir  (ir),
		.dec (dec)
	);

	grom_regfile u_regfile (
		.clk      (clk),
		.reset    (reset),
		.rd_a_sel (rd_a_sel),
		.rd_b_sel (rd_b_sel),
		.wr_en    (wr_en),
		.wr_sel   (wr_sel),
		.wr_data  (wr_data),
		.rd_a     (rd_a),
		.rd_b     (rd_b)
	);

	grom_alu u_alu (
		.clk    (clk),
		.reset  (reset),
		.cmd    (alu_cmd),
		.result (alu_res),
		.flags  (flags)
	);

	// Flat memory bus
	assign addr     = bus.addr;
	assign data_out = bus.data_out;
	assign we       = bus.we;

endmodule

`default_nettype wire

//--- testbench/grom_cpu_props.sv
`default_nettype none
`include "grom_defs.svh"

module grom_cpu_props (
	input wire logic                   clk,
	input wire logic                   reset,
	input wire logic [`GROM_ADDR_W-1:0] addr,
	input wire logic                   we,
	input wire logic                   hlt
);
	timeunit 1ns;
	timeprecision 1ps;

	we_single: assert property (@(posedge clk) disable iff (reset) we |=> !we)
		else $error("we high for two cycles in a row");

	// A halted machine never writes
	we_halted: assert property (@(posedge clk) disable iff (reset) hlt |-> !we)
		else $error("we high while hlt is high");

	hlt_sticky: assert property (@(posedge clk) $fell(hlt) |-> $past(reset))
		else $error("hlt fell without reset");

	we_data_page: assert property (@(posedge clk) disable iff (reset)
		we |-> addr[`GROM_ADDR_W-1:`GROM_ADDR_W-4] == `GROM_DATA_PAGE)
		else $error("store outside the data page");

endmodule

bind grom_cpu grom_cpu_props u_props (
	.clk   (clk),
	.reset (reset),
	.addr  (addr),
	.we    (we),
	.hlt   (hlt)
);

`default_nettype wire

//--- testbench/grom_cpu_tb.sv
`default_nettype none
`include "grom_defs.svh"

module grom_cpu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int NUM_PROGS = 20;
	localparam int MAX_INSTRS = 24;
	localparam int TIMEOUT_CYCLES = NUM_PROGS * 32 * 9 + 2240;
	localparam int HALT_WATCH = 20;    // Cycles watched after HALT
	localparam int OP_ADD = 0;
	localparam int OP_SUB = 1;
	localparam int OP_AND = 2;    // AND, OR, NOT, XOR follow in field order
	localparam int OP_OR = 3;
	localparam int OP_NOT = 4;

	logic                    clk;
	logic                    reset;
	logic [`GROM_ADDR_W-1:0] addr;
	logic [`GROM_DATA_W-1:0] data_in;
	logic [`GROM_DATA_W-1:0] data_out;
	logic                    we;
	logic                    hlt;

	logic [7:0]  mem [4096];
	logic [7:0]  model_mem [4096];
	logic [7:0]  rd_q;
	logic [7:0]  prog [2*MAX_INSTRS+17];    // Two bytes per slot plus the epilogue
	int          slot_addr [MAX_INSTRS+1];
	logic        is_jump [MAX_INSTRS];
	int          plen;
	logic [19:0] exp_q [$];    // {addr, data} in store order
	logic [7:0]  m_regs [4];
	logic        m_cf;
	logic        m_zf;
	logic        m_sf;
	logic [31:0] rng;
	int          errors;
	int          checks;
	int          cycles;
	int          prog_idx;

	grom_cpu dut (
		.clk      (clk),
		.reset    (reset),
		.addr     (addr),
		.data_in  (data_in),
		.data_out (data_out),
		.we       (we),
		.hlt      (hlt)
	);

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	// Synchronous memory, read data presented on the falling edge
	always @(posedge clk)
	begin
		rd_q <= mem[addr];
		if (we)
			mem[addr] = data_out;
	end

	always @(negedge clk)
		data_in = rd_q;

	always @(negedge clk)
	begin
		if (we === 1'b1)
			check_write(addr, data_out);
	end

	initial
	begin
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the CPU stopped reaching HALT", cycles);
		$display("tests failed");
		$finish;
	end

	function automatic logic [31:0] next_rand();
		logic [31:0] x;
		x = rng;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng = x;
		return x;
	endfunction

	function automatic logic [7:0] dropped_op();
		logic [7:0] b;
		case (next_rand() % 5)
			0: b = 8'h18 + 8'(next_rand() % 8);     // ADC, SBC
			1: b = 8'h40 + 8'(next_rand() % 16);    // Shifts
			2: b = 8'h70 + 8'(next_rand() % 15);    // Stack and segment moves
			3: b = 8'h87 + 8'(next_rand() % 9);
			default: b = 8'hA0 + 8'(next_rand() % 80);
		endcase
		return b;
	endfunction

	function automatic logic cond_met(input logic [2:0] c);
		logic t;
		case (c)
			3'd0: t = 1'b1;
			3'd1: t = m_cf;
			3'd2: t = !m_cf;
			3'd3: t = m_sf;
			3'd4: t = !m_sf;
			3'd5: t = m_zf;
			3'd6: t = !m_zf;
			default: t = 1'b0;
		endcase
		return t;
	endfunction

	function automatic logic [7:0] alu_model(input int op, input logic [7:0] a,
		input logic [7:0] b);
		logic [7:0] r;
		logic       c;
		c = 1'b0;
		case (op)
			OP_ADD:
			begin
				r = a + b;
				c = (int'(a) + int'(b)) > 255;
			end
			OP_SUB:
			begin
				r = a - b;
				c = a < b;    // Borrow
			end
			OP_AND: r = a & b;
			OP_OR: r = a | b;
			OP_NOT: r = ~b;
			default: r = a ^ b;
		endcase
		m_cf = c;
		m_zf = (r == 8'h00);
		m_sf = r[7];
		return r;
	endfunction

	task automatic emit(input logic [7:0] b);
		prog[plen] = b;
		plen++;
	endtask

	task automatic model_store(input logic [11:0] a, input logic [7:0] d);
		model_mem[a] = d;
		exp_q.push_back({a, d});
	endtask

	task automatic fill_memory();
		int a;
		for (a = 0; a < 4096; a++)
			mem[a] = 8'(a) ^ 8'(a >> 4) ^ 8'h3c;
	endtask

	task automatic gen_program();
		int         n;
		int         i;
		int         j;
		int         a;
		logic [7:0] op;
		n = 8 + int'(next_rand() % 17);
		plen = 0;
		for (i = 0; i < n; i++)
		begin
			slot_addr[i] = plen;
			case (next_rand() % 12)
				0: op = {4'h0, 4'(next_rand())};    // MOV
				1: op = {5'b00010, 3'(next_rand())};
				2: op = {4'h2, 4'(next_rand())};
				3: op = {4'h3, 4'(next_rand())};    // INC, DEC, CMP, TST
				4: op = {4'h5, 4'(next_rand())};
				5: op = {4'h6, 4'(next_rand())};
				6: op = {6'b111100, 2'(next_rand())};
				7: op = {6'b111101, 2'(next_rand())};    // LOADI
				8: op = {6'b111110, 2'(next_rand())};
				9: op = 8'h80 + 8'(next_rand() % 7);
				10: op = 8'h90;
				default: op = dropped_op();
			endcase
			is_jump[i] = (op[7:4] == 4'h8 && op[3:0] < 4'h7) || op == 8'h90;
			emit(op);
			if (op[7])
				emit(8'(next_rand()));
		end
		slot_addr[n] = plen;
		// Forward targets on instruction boundaries only
		for (i = 0; i < n; i++)
		begin
			if (is_jump[i])
			begin
				j = i + 1 + int'(next_rand() % (n - i));
				prog[slot_addr[i] + 1] = 8'(slot_addr[j]);
			end
		end
		for (i = 0; i < 4; i++)
		begin
			emit(8'hF8 | 8'(i));
			emit(8'hF0 + 8'(i));
		end
		emit(8'h7F);
		for (a = 0; a < plen; a++)
			mem[a] = prog[a];
		for (a = 0; a < 256; a++)
			mem[{`GROM_DATA_PAGE, 8'(a)}] = 8'(next_rand());
		for (a = 0; a < 4096; a++)
			model_mem[a] = mem[a];
	endtask

	task automatic run_model();
		logic [11:0] pc;
		logic [7:0]  op;
		logic [7:0]  opnd;
		logic [1:0]  rs;
		logic        halted;
		int          steps;
		pc = `GROM_RESET_PC;
		m_regs = '{default: 8'h00};
		m_cf = 1'b0;
		m_zf = 1'b0;
		m_sf = 1'b0;
		halted = 1'b0;
		steps = 0;
		while (!halted && steps < 200)
		begin
			steps++;
			op = model_mem[pc];
			rs = op[1:0];
			pc = pc + 12'd1;
			if (op[7])
			begin
				opnd = model_mem[pc];
				pc = pc + 12'd1;
				case (op[6:4])
					3'd0:
					begin
						if (!op[3] && cond_met(op[2:0]))
							pc = {pc[11:8], opnd};    // Same code page
					end
					3'd1: pc = {op[3:0], opnd};
					3'd7:
					begin
						case (op[3:2])
							2'd0: m_regs[rs] = opnd;
							2'd1: m_regs[rs] = model_mem[{`GROM_DATA_PAGE, opnd}];
							2'd2: model_store({`GROM_DATA_PAGE, opnd}, m_regs[rs]);
							default: ;
						endcase
					end
					default: ;
				endcase
			end
			else
			begin
				case (op[6:4])
					3'd0: m_regs[op[3:2]] = m_regs[rs];
					3'd1:
					begin
						if (!op[3])
							m_regs[0] = alu_model(op[2] ? OP_SUB : OP_ADD, m_regs[0], m_regs[rs]);
					end
					3'd2: m_regs[0] = alu_model(OP_AND + int'(op[3:2]), m_regs[0], m_regs[rs]);
					3'd3:
					begin
						case (op[3:2])
							2'd0: m_regs[rs] = alu_model(OP_ADD, m_regs[rs], 8'd1);
							2'd1: m_regs[rs] = alu_model(OP_SUB, m_regs[rs], 8'd1);
							2'd2: void'(alu_model(OP_SUB, m_regs[0], m_regs[rs]));
							default: void'(alu_model(OP_AND, m_regs[0], m_regs[rs]));
						endcase
					end
					3'd5: m_regs[op[3:2]] = model_mem[{`GROM_DATA_PAGE, m_regs[rs]}];
					3'd6: model_store({`GROM_DATA_PAGE, m_regs[op[3:2]]}, m_regs[rs]);
					3'd7: halted = (op == 8'h7F);
					default: ;
				endcase
			end
		end
		if (!halted)
		begin
			errors++;
			$display("program %0d: model ran %0d steps without reaching HALT", prog_idx, steps);
		end
	endtask

	task automatic check_write(input logic [11:0] a, input logic [7:0] d);
		logic [19:0] e;
		checks++;
		if (exp_q.size() == 0)
		begin
			errors++;
			$display("ERR %0t: unexpected write %03h <- %02h", $time, a, d);
		end
		else
		begin
			e = exp_q.pop_front();
			if (e != {a, d})
			begin
				errors++;
				$display("ERR %0t: write %03h <- %02h, expected %03h <- %02h",
					$time, a, d, e[19:8], e[7:0]);
			end
		end
	endtask

	task automatic check_reset_state();
		checks++;
		if (we !== 1'b0 || hlt !== 1'b0)
		begin
			errors++;
			$display("ERR %0t: we=%b hlt=%b after reset, expected both low", $time, we, hlt);
		end
		repeat (2) @(negedge clk);    // RESET state, then fetch-prepare
		checks++;
		if (addr !== 12'h000)
		begin
			errors++;
			$display("ERR %0t: first read address %03h, expected 000", $time, addr);
		end
	endtask

	task automatic watch_halt();
		int i;
		for (i = 0; i < HALT_WATCH; i++)
		begin
			@(negedge clk);
			checks++;
			if (hlt !== 1'b1)
			begin
				errors++;
				$display("ERR %0t: hlt dropped after HALT without reset", $time);
			end
		end
	endtask

	initial
	begin
		reset = 1'b1;
		data_in = '0;
		rng = 32'h56d1_d8d5;
		errors = 0;
		checks = 0;
		fill_memory();
		for (prog_idx = 0; prog_idx < NUM_PROGS; prog_idx++)
		begin
			@(negedge clk);
			reset = 1'b1;
			gen_program();
			run_model();
			repeat (2) @(negedge clk);
			reset = 1'b0;
			check_reset_state();
			while (!hlt)
				@(negedge clk);
			watch_halt();
			checks++;
			if (exp_q.size() != 0)
			begin
				errors++;
				$display("program %0d halted with %0d expected writes missing",
					prog_idx, exp_q.size());
				exp_q.delete();
			end
		end
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- compile.f
+incdir+src
src/grom_pkg.sv
src/grom_alu.sv
src/grom_regfile.sv
src/grom_decode.sv
src/grom_control.sv
src/grom_cpu.sv
testbench/grom_cpu_props.sv
testbench/grom_cpu_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and check the log

cd "$(dirname "$0")" || exit 1

TOP=grom_cpu_tb
LOG=sim.log

if ! verilator --binary --timing --assert --timescale 1ns/1ps -Wno-fatal \
	-f compile.f --top-module "$TOP"; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/V"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "tests failed" "$LOG"; then
	echo "FAIL"
	exit 1
fi
if ! grep -q "all tests passed" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi
echo "PASS"
exit 0
